// ==== logic/stlb_pkg.sv ====
package stlb_pkg;

	// ==================================================
	// Address widths shared by every pipeline stage
	// ==================================================

	localparam int VADR_W = 32;
	localparam int VPN_W = 20;

	// Controller state, one value per kind of pipeline work
	typedef enum logic [2:0] {
		ST_RST    = 3'd0,
		ST_RUN    = 3'd1,
		ST_UPDATE = 3'd2,
		ST_INVALL = 3'd3,
		ST_LOOKUP = 3'd4
	} tlb_state_t;

	// One translation entry as it sits in the entry RAM
	typedef struct packed {
		logic             valid;
		logic [7:0]       asid;
		logic [VPN_W-1:0] vpn;
		logic [19:0]      ppn;
		logic [2:0]       perm;
	} stlb_entry_t;

	// Layout of the RESULT word after a hit
	typedef struct packed {
		logic        hit;
		logic [7:0]  rsvd;
		logic [2:0]  perm;
		logic [19:0] ppn;
	} stlb_hit_view_t;

	// Layout of the RESULT word after a miss, echoing the page that missed
	typedef struct packed {
		logic             hit;
		logic [10:0]      rsvd;
		logic [VPN_W-1:0] vpn;
	} stlb_miss_view_t;

	// Bit 31 tells software which of the two views is meaningful
	typedef union packed {
		stlb_hit_view_t  hv;
		stlb_miss_view_t mv;
	} stlb_result_u;

	// ==================================================
	// Register map and command codes
	// ==================================================

	localparam logic [7:0] REG_VADR   = 8'h00;
	localparam logic [7:0] REG_PTE    = 8'h04;
	localparam logic [7:0] REG_CMD    = 8'h08;
	localparam logic [7:0] REG_STATUS = 8'h0C;
	localparam logic [7:0] REG_RESULT = 8'h10;
	localparam logic [7:0] REG_ASID   = 8'h14;

	localparam logic [1:0] CMD_UPDATE = 2'd1;
	localparam logic [1:0] CMD_INVALL = 2'd2;
	localparam logic [1:0] CMD_LOOKUP = 2'd3;

endpackage

// ==== logic/stlb_axil_regs.sv ====
`timescale 1ns/100ps

module stlb_axil_regs (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [7:0]                    awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [31:0]                   wdata,
	input  logic [3:0]                    wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	input  logic [7:0]                    araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [31:0]                   rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready,
	input  logic                          busy,
	input  logic                          result_valid,
	input  stlb_pkg::stlb_result_u        result,
	output logic                          cmd_valid,
	output logic [1:0]                    cmd_code,
	output logic [stlb_pkg::VADR_W-1:0]   cmd_vadr,
	output logic [7:0]                    cmd_asid,
	output logic [19:0]                   cmd_ppn,
	output logic [2:0]                    cmd_perm
);
	import stlb_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic              wr_go;
	logic              rd_go;
	logic              is_cmd;
	logic              code_ok;
	logic              busy_any;
	logic [VADR_W-1:0] vadr_q;
	logic [7:0]        asid_q;
	logic [19:0]       ppn_q;
	logic [2:0]        perm_q;
	logic              done;
	stlb_result_u      result_q;
	logic [31:0]       rd_word;

	// ==================================================
	// Write channel
	// ==================================================

	// Address and data are taken together, and only once the last response has gone
	assign wr_go = awvalid && wvalid && !bvalid;
	assign awready = wr_go;
	assign wready = wr_go;

	assign is_cmd = awaddr == REG_CMD;
	assign code_ok = wdata[31:2] == '0 && wdata[1:0] inside {CMD_UPDATE, CMD_INVALL, CMD_LOOKUP};

	// A pulse still on its way to the controller counts as busy
	assign busy_any = busy || cmd_valid;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			cmd_valid <= 1'b0;
			done <= 1'b0;
			vadr_q <= '0;
			asid_q <= '0;
			ppn_q <= '0;
			perm_q <= '0;
			result_q <= '0;
		end
		else
		begin
			cmd_valid <= 1'b0;
			if (wr_go)
			begin
				bvalid <= 1'b1;
				// A refused command is reported and never reaches the pipeline
				bresp <= (is_cmd && (!code_ok || busy_any)) ? RESP_SLVERR : RESP_OKAY;
				cmd_valid <= is_cmd && code_ok && !busy_any;
				case (awaddr)
				REG_VADR:
					vadr_q <= wdata;
				REG_PTE:
				begin
					ppn_q <= wdata[19:0];
					perm_q <= wdata[22:20];
				end
				REG_ASID:
					asid_q <= wdata[7:0];
				default:
					;
				endcase
			end
			else if (bready)
				bvalid <= 1'b0;
			// Done marks a finished lookup until software issues the next command
			if (result_valid)
			begin
				done <= 1'b1;
				result_q <= result;
			end
			else if (cmd_valid)
				done <= 1'b0;
		end
	end

	// The code is latched even when refused, so CMD reads back the last value written
	always_ff @(posedge clk)
	begin
		if (wr_go && is_cmd)
			cmd_code <= wdata[1:0];
	end

	assign cmd_vadr = vadr_q;
	assign cmd_asid = asid_q;
	assign cmd_ppn = ppn_q;
	assign cmd_perm = perm_q;

	// ==================================================
	// Read channel
	// ==================================================

	assign arready = !rvalid;
	assign rd_go = arvalid && arready;
	assign rresp = RESP_OKAY;

	always_comb
	begin
		case (araddr)
		REG_VADR:   rd_word = vadr_q;
		REG_PTE:    rd_word = {9'd0, perm_q, ppn_q};
		REG_CMD:    rd_word = {30'd0, cmd_code};
		REG_STATUS: rd_word = {30'd0, done, busy_any};
		REG_RESULT: rd_word = result_q;
		REG_ASID:   rd_word = {24'd0, asid_q};
		default:    rd_word = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rvalid <= 1'b0;
		else if (rd_go)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// rdata only moves on acceptance, so it stays put while the master stalls
	always_ff @(posedge clk)
	begin
		if (rd_go)
			rdata <= rd_word;
	end

	// Responses stay quiet through reset
	a_no_resp_in_reset: assert property (@(posedge clk) rst |=> !bvalid && !rvalid);

	// Byte strobes are not decoded, so every accepted write must be full-word
	a_full_word: assert property (@(posedge clk) disable iff (rst) wr_go |-> wstrb == 4'hF);

endmodule

// ==== logic/stlb_ctrl_fsm.sv ====
`timescale 1ns/100ps

module stlb_ctrl_fsm #(
	parameter int ENTRIES = 64
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         cmd_valid,
	input  logic [1:0]                   cmd_code,
	input  logic                         ad_busy,
	input  logic                         result_valid,
	output stlb_pkg::tlb_state_t         state,
	output logic [$clog2(ENTRIES)-1:0]   walk_index,
	output logic                         busy
);
	import stlb_pkg::*;

	localparam int IDX_W = $clog2(ENTRIES);
	localparam logic [IDX_W-1:0] LAST_INDEX = IDX_W'(ENTRIES - 1);

	logic walk_last;
	logic lookup_wait;

	assign walk_last = walk_index == LAST_INDEX;

	// ==================================================
	// State register and walk counter
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_RST;
			walk_index <= '0;
			lookup_wait <= 1'b0;
		end
		else
		begin
			case (state)
			ST_RST, ST_INVALL:
			begin
				// One index per cycle, and the counter wraps to zero on the last one
				walk_index <= walk_index + 1'b1;
				if (walk_last)
					state <= ST_RUN;
			end
			ST_RUN:
			begin
				if (cmd_valid)
				begin
					case (cmd_code)
					CMD_UPDATE: state <= ST_UPDATE;
					CMD_INVALL: state <= ST_INVALL;
					CMD_LOOKUP: state <= ST_LOOKUP;
					default:    state <= ST_RUN;
					endcase
				end
			end
			// Single entry commands spend one cycle here and let the pipeline finish
			ST_UPDATE, ST_LOOKUP:
				state <= ST_RUN;
			default:
				state <= ST_RUN;
			endcase

			// A lookup stays outstanding until the compare stage answers
			if (state == ST_LOOKUP)
				lookup_wait <= 1'b1;
			else if (result_valid)
				lookup_wait <= 1'b0;
		end
	end

	// ==================================================
	// Busy
	// ==================================================

	// Busy covers the state itself, anything left in the ad stage and the RAM and compare
	// stages of a lookup, falling in the same cycle as result_valid
	assign busy = state != ST_RUN || ad_busy || (lookup_wait && !result_valid);

	// The register slave only issues commands when the controller is idle
	a_cmd_in_run: assert property (@(posedge clk) disable iff (rst)
		cmd_valid |-> state == ST_RUN);

endmodule

// ==== logic/stlb_ad_select.sv ====
`timescale 1ns/100ps

module stlb_ad_select #(
	parameter int ENTRIES = 64,
	parameter int PAGE_SIZE = 4096
) (
	input  logic                          clk,
	input  logic                          rst,
	input  stlb_pkg::tlb_state_t          state,
	input  logic [$clog2(ENTRIES)-1:0]    walk_index,
	input  logic [stlb_pkg::VADR_W-1:0]   cmd_vadr,
	input  logic [7:0]                    cmd_asid,
	input  logic [19:0]                   cmd_ppn,
	input  logic [2:0]                    cmd_perm,
	output logic                          ram_we,
	output logic [$clog2(ENTRIES)-1:0]    ram_index,
	output stlb_pkg::stlb_entry_t         ram_wdata,
	output logic                          lookup_pending,
	output logic [stlb_pkg::VPN_W-1:0]    key_vpn,
	output logic [7:0]                    key_asid,
	output logic                          ad_busy
);
	import stlb_pkg::*;

	localparam int IDX_W = $clog2(ENTRIES);
	localparam int PG_SHIFT = $clog2(PAGE_SIZE);

	logic [VPN_W-1:0] cmd_vpn;
	logic [IDX_W-1:0] cmd_index;

	// Direct-mapped, so the low page number bits pick the entry
	assign cmd_vpn = VPN_W'(cmd_vadr >> PG_SHIFT);
	assign cmd_index = cmd_vpn[IDX_W-1:0];

	// Write enable and the lookup flag are the only control bits of this stage
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ram_we <= 1'b0;
			lookup_pending <= 1'b0;
		end
		else
		begin
			ram_we <= state inside {ST_RST, ST_UPDATE, ST_INVALL};
			lookup_pending <= state == ST_LOOKUP;
		end
	end

	// RAM address and data, chosen by what the controller is doing
	always_ff @(posedge clk)
	begin
		case (state)
		ST_RST, ST_INVALL:
		begin
			ram_index <= walk_index;
			ram_wdata <= '0;
		end
		ST_UPDATE:
		begin
			ram_index <= cmd_index;
			ram_wdata.valid <= 1'b1;
			ram_wdata.asid <= cmd_asid;
			ram_wdata.vpn <= cmd_vpn;
			ram_wdata.ppn <= cmd_ppn;
			ram_wdata.perm <= cmd_perm;
		end
		ST_LOOKUP:
		begin
			ram_index <= cmd_index;
			key_vpn <= cmd_vpn;
			key_asid <= cmd_asid;
		end
		default:
			;
		endcase
	end

	assign ad_busy = ram_we || lookup_pending;

	// An idle controller never sends a write into the RAM
	a_no_write_from_run: assert property (@(posedge clk) disable iff (rst)
		state == ST_RUN |=> !ram_we);

endmodule

// ==== logic/stlb_entry_ram.sv ====
`timescale 1ns/100ps

module stlb_entry_ram #(
	parameter int ENTRIES = 64
) (
	input  logic                          clk,
	input  logic                          ram_we,
	input  logic [$clog2(ENTRIES)-1:0]    ram_index,
	input  stlb_pkg::stlb_entry_t         ram_wdata,
	input  logic                          lookup_pending,
	input  logic [stlb_pkg::VPN_W-1:0]    key_vpn,
	input  logic [7:0]                    key_asid,
	output stlb_pkg::stlb_entry_t         rd_entry,
	output logic                          rd_pending,
	output logic [stlb_pkg::VPN_W-1:0]    rd_vpn,
	output logic [7:0]                    rd_asid
);
	import stlb_pkg::*;

	// ==================================================
	// Entry storage
	// ==================================================

	stlb_entry_t mem [ENTRIES];

	// Single port with a registered read, so a read in the cycle of a write sees old data
	always_ff @(posedge clk)
	begin
		if (ram_we)
			mem[ram_index] <= ram_wdata;
		rd_entry <= mem[ram_index];
	end

	// The lookup key rides one register alongside the read data
	// rd_pending follows lookup_pending, which the ad stage clears in reset
	always_ff @(posedge clk)
	begin
		rd_pending <= lookup_pending;
		rd_vpn <= key_vpn;
		rd_asid <= key_asid;
	end

endmodule

// ==== logic/stlb_tag_compare.sv ====
`timescale 1ns/100ps

module stlb_tag_compare (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          rd_pending,
	input  stlb_pkg::stlb_entry_t         rd_entry,
	input  logic [stlb_pkg::VPN_W-1:0]    rd_vpn,
	input  logic [7:0]                    rd_asid,
	output logic                          result_valid,
	output stlb_pkg::stlb_result_u        result
);
	import stlb_pkg::*;

	logic         hit;
	stlb_result_u word;

	// ==================================================
	// Hit test
	// ==================================================

	// The full vpn is stored, so aliasing pages at one index are told apart here
	assign hit = rd_entry.valid && rd_entry.vpn == rd_vpn && rd_entry.asid == rd_asid;

	// Build the RESULT word in whichever view the hit bit selects
	always_comb
	begin
		word = '0;
		if (hit)
		begin
			word.hv.hit = 1'b1;
			word.hv.perm = rd_entry.perm;
			word.hv.ppn = rd_entry.ppn;
		end
		else
		begin
			word.mv.hit = 1'b0;
			// Software sees which page missed
			word.mv.vpn = rd_vpn;
		end
	end

	// ==================================================
	// Result register
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst)
			result_valid <= 1'b0;
		else
			result_valid <= rd_pending;
	end

	// The word only changes when a lookup completes
	always_ff @(posedge clk)
	begin
		if (rd_pending)
			result <= word;
	end

endmodule

// ==== logic/stlb_top.sv ====
`timescale 1ns/100ps

module stlb_top #(
	parameter int ENTRIES = 64,
	parameter int PAGE_SIZE = 4096
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [7:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [7:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);
	import stlb_pkg::*;

	localparam int IDX_W = $clog2(ENTRIES);

	// Command from the register slave
	logic              cmd_valid;
	logic [1:0]        cmd_code;
	logic [VADR_W-1:0] cmd_vadr;
	logic [7:0]        cmd_asid;
	logic [19:0]       cmd_ppn;
	logic [2:0]        cmd_perm;

	// Controller and ad stage
	tlb_state_t        state;
	logic [IDX_W-1:0]  walk_index;
	logic              busy;
	logic              ad_busy;
	logic              ram_we;
	logic [IDX_W-1:0]  ram_index;
	stlb_entry_t       ram_wdata;
	logic              lookup_pending;
	logic [VPN_W-1:0]  key_vpn;
	logic [7:0]        key_asid;

	// RAM read and compare
	stlb_entry_t       rd_entry;
	logic              rd_pending;
	logic [VPN_W-1:0]  rd_vpn;
	logic [7:0]        rd_asid;
	logic              result_valid;
	stlb_result_u      result;

	// Every port name matches its net, so the stages connect by name
	stlb_axil_regs u_regs (.*);

	stlb_ctrl_fsm #(.ENTRIES(ENTRIES)) u_ctrl (.*);

	stlb_ad_select #(.ENTRIES(ENTRIES), .PAGE_SIZE(PAGE_SIZE)) u_ad (.*);

	stlb_entry_ram #(.ENTRIES(ENTRIES)) u_ram (.*);

	stlb_tag_compare u_cmp (.*);

endmodule

// ==== bench/stlb_axil_tasks.svh ====
`ifndef STLB_AXIL_TASKS_SVH
`define STLB_AXIL_TASKS_SVH

// ==================================================
// AXI4-Lite master tasks
// ==================================================

// One full-word write, the expected bresp is checked by the bench assertion
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic [1:0] resp);
	begin
		exp_bresp = resp;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		// awready is combinational, so it is looked at mid-cycle where it has settled
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!bvalid)
			abort_run("bvalid did not rise after an accepted write");
		// bready is already high, so this edge completes the response
		@(posedge clk);
		#1;
		bready = 1'b0;
	end
endtask

// One read, rready is held low for stall cycles once rvalid is up
task automatic read_reg(input logic [7:0] addr, input logic [31:0] expv, input logic [31:0] mask,
	input int stall, output logic [31:0] data);
	begin
		exp_rdata = expv;
		rd_mask = mask;
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b0;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		if (!rvalid)
			abort_run("rvalid did not rise after an accepted read");
		data = rdata;
		repeat (stall)
		begin
			@(posedge clk);
			#1;
		end
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	end
endtask

// Poll STATUS until busy clears, only the reserved bits are checked on each poll
task automatic wait_idle();
	logic [31:0] status;
	int          polls;
	begin
		polls = 0;
		status = 32'd1;
		while (status[0])
		begin
			if (polls == MAX_POLLS)
				abort_run("busy in REG_STATUS never cleared");
			read_reg(REG_STATUS, 32'd0, 32'hFFFF_FFFC, 0, status);
			polls++;
		end
	end
endtask

`endif

// ==== bench/stlb_tb.sv ====
`timescale 1ns/100ps

module stlb_tb;
	import stlb_pkg::*;

	localparam int ENTRIES = 64;
	localparam int IDX_W = $clog2(ENTRIES);
	localparam int CLK_NS = 8;
	localparam int MAX_POLLS = 100;
	// Three full walks plus a budget of 20 cycles for each of 180 transactions, doubled
	localparam int MAX_TXNS = 180;
	localparam int WATCHDOG_NS = 2 * (3 * ENTRIES + MAX_TXNS * 20) * CLK_NS;
	localparam logic [1:0] RESP_OK = 2'b00;
	localparam logic [1:0] RESP_ERR = 2'b10;

	logic        clk;
	logic        rst;
	logic [7:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [7:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	// Expected responses, set by the bus tasks before each transfer
	logic [31:0] exp_rdata;
	logic [31:0] rd_mask;
	logic [1:0]  exp_bresp;
	integer      seed;

	// Reference copy of the direct-mapped table
	logic             m_valid [ENTRIES];
	logic [7:0]       m_asid [ENTRIES];
	logic [VPN_W-1:0] m_vpn [ENTRIES];
	logic [19:0]      m_ppn [ENTRIES];
	logic [2:0]       m_perm [ENTRIES];
	logic [31:0]      used_vadr [$];
	logic [7:0]       used_asid [$];

	`include "stlb_axil_tasks.svh"

	stlb_top #(.ENTRIES(ENTRIES), .PAGE_SIZE(4096)) DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_NS / 2) clk = ~clk;
	end

	// ==================================================
	// Failure reporting and the table model
	// ==================================================

	task automatic report_mismatch(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		begin
			$display("ERR t=%0t %s expected %h actual %h", $time, name, expv, actv);
			$display("TESTBENCH FAILED");
			$fatal(1, "Wrong value on %s", name);
		end
	endtask

	task automatic abort_run(input string why);
		begin
			$display("Run stopped at t=%0t because %s", $time, why);
			$display("TESTBENCH FAILED");
			$fatal(1, "%s", why);
		end
	endtask

	function automatic logic [31:0] random_word();
		random_word = $random(seed);
	endfunction

	task automatic clear_model();
		begin
			for (int i = 0; i < ENTRIES; i++)
				m_valid[IDX_W'(i)] = 1'b0;
		end
	endtask

	// A hit needs a valid entry whose page (bits 31..12) and ASID both match
	function automatic logic [31:0] expected_result(input logic [31:0] vadr, input logic [7:0] asid);
		logic [19:0]      vpn;
		logic [IDX_W-1:0] idx;
		begin
			vpn = vadr[31:12];
			idx = vpn[IDX_W-1:0];
			if (m_valid[idx] && m_vpn[idx] == vpn && m_asid[idx] == asid)
				expected_result = {1'b1, 8'd0, m_perm[idx], m_ppn[idx]};
			else
				expected_result = {1'b0, 11'd0, vpn};
		end
	endfunction

	// ==================================================
	// Commands
	// ==================================================

	task automatic update_entry(input logic [31:0] vadr, input logic [7:0] asid,
		input logic [19:0] ppn, input logic [2:0] perm);
		logic [IDX_W-1:0] idx;
		logic [31:0]      word;
		begin
			write_reg(REG_VADR, vadr, RESP_OK);
			write_reg(REG_ASID, {24'd0, asid}, RESP_OK);
			write_reg(REG_PTE, {9'd0, perm, ppn}, RESP_OK);
			write_reg(REG_CMD, {30'd0, CMD_UPDATE}, RESP_OK);
			wait_idle();
			// The accepted update clears done and nothing sets it again
			read_reg(REG_STATUS, 32'd0, 32'hFFFF_FFFF, 0, word);
			idx = vadr[12 +: IDX_W];
			m_valid[idx] = 1'b1;
			m_asid[idx] = asid;
			m_vpn[idx] = vadr[31:12];
			m_ppn[idx] = ppn;
			m_perm[idx] = perm;
		end
	endtask

	task automatic lookup_entry(input logic [31:0] vadr, input logic [7:0] asid, input int stall);
		logic [31:0] word;
		begin
			write_reg(REG_VADR, vadr, RESP_OK);
			write_reg(REG_ASID, {24'd0, asid}, RESP_OK);
			write_reg(REG_CMD, {30'd0, CMD_LOOKUP}, RESP_OK);
			wait_idle();
			// A finished lookup leaves done set with busy clear
			read_reg(REG_STATUS, 32'h0000_0002, 32'hFFFF_FFFF, 0, word);
			read_reg(REG_RESULT, expected_result(vadr, asid), 32'hFFFF_FFFF, stall, word);
		end
	endtask

	task automatic invalidate_all();
		begin
			write_reg(REG_CMD, {30'd0, CMD_INVALL}, RESP_OK);
			wait_idle();
			clear_model();
		end
	endtask

	// ==================================================
	// Response checks
	// ==================================================

	a_rdata: assert property (@(posedge clk) disable iff (rst)
		rvalid && rready |-> (rdata & rd_mask) == (exp_rdata & rd_mask))
		else report_mismatch("rdata", exp_rdata, rdata);

	a_rresp: assert property (@(posedge clk) disable iff (rst)
		rvalid && rready |-> rresp == RESP_OK)
		else report_mismatch("rresp", {30'd0, RESP_OK}, {30'd0, rresp});

	a_bresp: assert property (@(posedge clk) disable iff (rst)
		bvalid && bready |-> bresp == exp_bresp)
		else report_mismatch("bresp", {30'd0, exp_bresp}, {30'd0, bresp});

	// Address and data of a write are accepted together
	a_ready_pair: assert property (@(posedge clk) disable iff (rst)
		awready == wready)
		else report_mismatch("wready", {31'd0, awready}, {31'd0, wready});

	// A stalled read keeps its valid and its data until rready
	a_rd_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else abort_run("rvalid or rdata changed while rready was low");

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$fatal(1, "Timeout");
	end

	// ==================================================
	// Stimulus
	// ==================================================

	initial
	begin
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] word;
		logic [7:0]  as;
		rst = 1'b1;
		awaddr = 8'd0;
		awvalid = 1'b0;
		wdata = 32'd0;
		wstrb = 4'hF;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = 8'd0;
		arvalid = 1'b0;
		rready = 1'b0;
		exp_rdata = 32'd0;
		rd_mask = 32'd0;
		exp_bresp = RESP_OK;
		seed = 32'h4d7fa0c5;
		clear_model();
		repeat (4)
			@(posedge clk);
		#1;
		rst = 1'b0;
		// The clear walk after reset shows as busy
		wait_idle();

		// Freshly cleared table misses everywhere
		repeat (3)
		begin
			word = random_word();
			lookup_entry(random_word(), word[7:0], 0);
		end

		// Hit in the same page, then misses on another ASID and on an aliasing tag
		word = random_word();
		va = random_word();
		as = word[7:0];
		update_entry(va, as, word[27:8], word[30:28]);
		lookup_entry(va ^ 32'h0000_0ABC, as, 0);
		lookup_entry(va, as ^ 8'h01, 0);
		vb = va ^ (32'd1 << (IDX_W + 12));
		lookup_entry(vb, as, 0);
		// The alias takes over the index and the old page misses
		update_entry(vb, as, ~word[27:8], word[2:0]);
		lookup_entry(va, as, 0);
		lookup_entry(vb, as, 0);
		used_vadr.push_back(vb);
		used_asid.push_back(as);

		for (int n = 0; n < 6; n++)
		begin
			word = random_word();
			va = random_word();
			used_vadr.push_back(va);
			used_asid.push_back(word[7:0]);
			update_entry(va, word[7:0], word[27:8], word[30:28]);
		end
		foreach (used_vadr[k])
			lookup_entry(used_vadr[k], used_asid[k], 0);

		// After invalidate-all everything written so far misses
		invalidate_all();
		foreach (used_vadr[k])
			lookup_entry(used_vadr[k], used_asid[k], 0);

		// Commands while busy and unknown codes are refused and change nothing
		word = random_word();
		va = random_word();
		as = word[7:0];
		update_entry(va, as, word[27:8], word[30:28]);
		vb = random_word();
		write_reg(REG_VADR, vb, RESP_OK);
		write_reg(REG_CMD, {30'd0, CMD_INVALL}, RESP_OK);
		write_reg(REG_CMD, {30'd0, CMD_UPDATE}, RESP_ERR);
		write_reg(REG_CMD, 32'd0, RESP_ERR);
		wait_idle();
		clear_model();
		write_reg(REG_CMD, 32'd0, RESP_ERR);
		write_reg(REG_CMD, 32'h0000_0007, RESP_ERR);
		read_reg(REG_VADR, vb, 32'hFFFF_FFFF, 0, word);
		read_reg(REG_ASID, {24'd0, as}, 32'hFFFF_FFFF, 0, word);
		read_reg(8'h18, 32'd0, 32'hFFFF_FFFF, 0, word);
		lookup_entry(va, as, 0);
		lookup_entry(vb, as, 0);

		// RESULT read with the master stalling on rready
		word = random_word();
		update_entry(va, as, word[19:0], word[22:20]);
		lookup_entry(va, as, 5);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+bench
logic/stlb_pkg.sv
logic/stlb_axil_regs.sv
logic/stlb_ctrl_fsm.sv
logic/stlb_ad_select.sv
logic/stlb_entry_ram.sv
logic/stlb_tag_compare.sv
logic/stlb_top.sv
bench/stlb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the STLB design and its testbench with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module stlb_tb -f vlog.f -o Vstlb_tb
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/Vstlb_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation ended with status $sim_status"
	exit $sim_status
fi

exit 0
